// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_periph_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
SOURCES   := $(wildcard logic/*.sv test/*.sv)
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== flist.f ====
logic/soc_pkg.sv
logic/axi_lite_if.sv
logic/axi_addr_router.sv
logic/clint.sv
logic/scratch_ram.sv
logic/periph_top.sv
test/tb_clk_gen.sv
test/tb_periph_top.sv

// ==== logic/axi_addr_router.sv ====
`timescale 1ns/1ps

module axi_addr_router #(
    parameter int ram_depth = 64
) (
    input logic             clk,
    input logic             rst,
    axi_lite_if.subordinate mgr,
    axi_lite_if.manager     clint_port,
    axi_lite_if.manager     ram_port
);
    import soc_pkg::*;

    typedef enum logic [1:0] {tgt_none, tgt_clint, tgt_ram} tgt_t;
    typedef enum logic [1:0] {rd_idle, rd_fwd, rd_wait, rd_resp} rd_state_t;
    typedef enum logic [1:0] {wr_idle, wr_fwd, wr_wait, wr_resp} wr_state_t;

    localparam logic [addr_width-1:0] ram_bytes = addr_width'(ram_depth * strb_width);

    rd_state_t             rd_state;
    wr_state_t             wr_state;
    tgt_t                  rd_tgt;
    tgt_t                  wr_tgt;
    tgt_t                  wr_dec;
    logic [addr_width-1:0] araddr_q;
    logic [addr_width-1:0] awaddr_q;
    logic [data_width-1:0] rdata_q;
    logic [data_width-1:0] wdata_q;
    logic [strb_width-1:0] wstrb_q;
    resp_t                 rresp_q;
    resp_t                 bresp_q;
    logic                  aw_done;
    logic                  w_done;
    logic                  aw_sent;
    logic                  w_sent;
    logic                  ar_fire;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  wr_both;
    logic                  sel_arready;
    logic                  sel_rvalid;
    logic [data_width-1:0] sel_rdata;
    resp_t                 sel_rresp;
    logic                  sel_awready;
    logic                  sel_wready;
    logic                  sel_bvalid;
    resp_t                 sel_bresp;

    function automatic tgt_t decode(input logic [addr_width-1:0] addr);
        if (addr >= clint_base && addr - clint_base < clint_span) begin
            return tgt_clint;
        end
        if (addr >= ram_base && addr - ram_base < ram_bytes) begin
            return tgt_ram;
        end
        return tgt_none;
    endfunction

    // manager side
    assign mgr.arready = rd_state == rd_idle;
    assign mgr.rvalid  = rd_state == rd_resp;
    assign mgr.rdata   = rdata_q;
    assign mgr.rresp   = rresp_q;
    assign mgr.awready = wr_state == wr_idle && !aw_done;
    assign mgr.wready  = wr_state == wr_idle && !w_done;
    assign mgr.bvalid  = wr_state == wr_resp;
    assign mgr.bresp   = bresp_q;

    assign ar_fire = mgr.arvalid && mgr.arready;
    assign aw_fire = mgr.awvalid && mgr.awready;
    assign w_fire  = mgr.wvalid && mgr.wready;
    assign wr_both = (aw_done || aw_fire) && (w_done || w_fire);
    // address may arrive in the same cycle the write completes
    assign wr_dec  = decode(aw_done ? awaddr_q : mgr.awaddr);

    // request payload goes to both subordinates, valids pick one
    assign clint_port.araddr  = araddr_q;
    assign ram_port.araddr    = araddr_q;
    assign clint_port.awaddr  = awaddr_q;
    assign ram_port.awaddr    = awaddr_q;
    assign clint_port.wdata   = wdata_q;
    assign ram_port.wdata     = wdata_q;
    assign clint_port.wstrb   = wstrb_q;
    assign ram_port.wstrb     = wstrb_q;

    assign clint_port.arvalid = rd_state == rd_fwd && rd_tgt == tgt_clint;
    assign ram_port.arvalid   = rd_state == rd_fwd && rd_tgt == tgt_ram;
    assign clint_port.rready  = rd_state == rd_wait && rd_tgt == tgt_clint;
    assign ram_port.rready    = rd_state == rd_wait && rd_tgt == tgt_ram;
    assign clint_port.awvalid = wr_state == wr_fwd && wr_tgt == tgt_clint && !aw_sent;
    assign ram_port.awvalid   = wr_state == wr_fwd && wr_tgt == tgt_ram && !aw_sent;
    assign clint_port.wvalid  = wr_state == wr_fwd && wr_tgt == tgt_clint && !w_sent;
    assign ram_port.wvalid    = wr_state == wr_fwd && wr_tgt == tgt_ram && !w_sent;
    assign clint_port.bready  = wr_state == wr_wait && wr_tgt == tgt_clint;
    assign ram_port.bready    = wr_state == wr_wait && wr_tgt == tgt_ram;

    // response mux
    assign sel_arready = rd_tgt == tgt_clint ? clint_port.arready : ram_port.arready;
    assign sel_rvalid  = rd_tgt == tgt_clint ? clint_port.rvalid : ram_port.rvalid;
    assign sel_rdata   = rd_tgt == tgt_clint ? clint_port.rdata : ram_port.rdata;
    assign sel_rresp   = rd_tgt == tgt_clint ? clint_port.rresp : ram_port.rresp;
    assign sel_awready = wr_tgt == tgt_clint ? clint_port.awready : ram_port.awready;
    assign sel_wready  = wr_tgt == tgt_clint ? clint_port.wready : ram_port.wready;
    assign sel_bvalid  = wr_tgt == tgt_clint ? clint_port.bvalid : ram_port.bvalid;
    assign sel_bresp   = wr_tgt == tgt_clint ? clint_port.bresp : ram_port.bresp;

    // read fsm
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_state <= rd_idle;
            rd_tgt   <= tgt_none;
            rresp_q  <= resp_okay;
        end else begin
            case (rd_state)
                rd_idle: begin
                    if (ar_fire) begin
                        rd_tgt <= decode(mgr.araddr);
                        if (decode(mgr.araddr) == tgt_none) begin
                            rresp_q  <= resp_decerr;
                            rd_state <= rd_resp;
                        end else begin
                            rd_state <= rd_fwd;
                        end
                    end
                end
                rd_fwd: begin
                    if (sel_arready) rd_state <= rd_wait;
                end
                rd_wait: begin
                    if (sel_rvalid) begin
                        rresp_q  <= sel_rresp;
                        rd_state <= rd_resp;
                    end
                end
                rd_resp: begin
                    if (mgr.rready) rd_state <= rd_idle;
                end
                default: rd_state <= rd_idle;
            endcase
        end
    end

    // write fsm, aw and w halves collected in any order
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_state <= wr_idle;
            wr_tgt   <= tgt_none;
            bresp_q  <= resp_okay;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
            aw_sent  <= 1'b0;
            w_sent   <= 1'b0;
        end else begin
            case (wr_state)
                wr_idle: begin
                    if (wr_both) begin
                        aw_done  <= 1'b0;
                        w_done   <= 1'b0;
                        aw_sent  <= 1'b0;
                        w_sent   <= 1'b0;
                        wr_tgt   <= wr_dec;
                        bresp_q  <= resp_decerr;
                        wr_state <= wr_dec == tgt_none ? wr_resp : wr_fwd;
                    end else begin
                        aw_done <= aw_done | aw_fire;
                        w_done  <= w_done | w_fire;
                    end
                end
                wr_fwd: begin
                    aw_sent <= aw_sent | sel_awready;
                    w_sent  <= w_sent | sel_wready;
                    if ((aw_sent || sel_awready) && (w_sent || sel_wready)) begin
                        wr_state <= wr_wait;
                    end
                end
                wr_wait: begin
                    if (sel_bvalid) begin
                        bresp_q  <= sel_bresp;
                        wr_state <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (mgr.bready) wr_state <= wr_idle;
                end
                default: wr_state <= wr_idle;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (ar_fire) araddr_q <= mgr.araddr;
        if (aw_fire) awaddr_q <= mgr.awaddr;
        if (w_fire) begin
            wdata_q <= mgr.wdata;
            wstrb_q <= mgr.wstrb;
        end
        // decode errors read as zero
        if (ar_fire) rdata_q <= '0;
        else if (rd_state == rd_wait && sel_rvalid) rdata_q <= sel_rdata;
    end

    a_one_sub_rvalid: assert property (@(posedge clk) disable iff (rst)
        rd_state != rd_idle |-> !(clint_port.rvalid && ram_port.rvalid));

    // decode error after 1 cycle, forwarded read after 3
    a_rvalid_after_ar: assert property (@(posedge clk) disable iff (rst)
        $rose(mgr.rvalid) |-> $past(ar_fire) || $past(ar_fire, 3));

endmodule

// ==== logic/axi_lite_if.sv ====
`timescale 1ns/1ps

interface axi_lite_if;
    import soc_pkg::*;

    logic [addr_width-1:0] araddr;
    logic                  arvalid;
    logic                  arready;

    logic [data_width-1:0] rdata;
    resp_t                 rresp;
    logic                  rvalid;
    logic                  rready;

    logic [addr_width-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;

    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;

    resp_t                 bresp;
    logic                  bvalid;
    logic                  bready;

    modport manager (
        output araddr, arvalid, input arready,
        input rdata, rresp, rvalid, output rready,
        output awaddr, awvalid, input awready,
        output wdata, wstrb, wvalid, input wready,
        input bresp, bvalid, output bready
    );

    modport subordinate (
        input araddr, arvalid, output arready,
        output rdata, rresp, rvalid, input rready,
        input awaddr, awvalid, output awready,
        input wdata, wstrb, wvalid, output wready,
        output bresp, bvalid, input bready
    );

endinterface

// ==== logic/clint.sv ====
`timescale 1ns/1ps

module clint (
    input  logic            clk,
    input  logic            rst,
    axi_lite_if.subordinate bus,
    output logic            mtip
);
    import soc_pkg::*;

    logic [63:0]           mtime;
    logic [63:0]           mtimecmp;
    logic [7:0]            awofs_q;
    logic [data_width-1:0] wdata_q;
    logic [strb_width-1:0] wstrb_q;
    logic                  ar_fire;
    logic                  r_fire;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  b_fire;
    logic                  wr_go;
    logic [7:0]            wr_ofs;
    logic [data_width-1:0] wr_data;
    logic [strb_width-1:0] wr_strb;

    assign ar_fire = bus.arvalid && bus.arready;
    assign r_fire  = bus.rvalid && bus.rready;
    assign aw_fire = bus.awvalid && bus.awready;
    assign w_fire  = bus.wvalid && bus.wready;
    assign b_fire  = bus.bvalid && bus.bready;

    // both halves seen, now or earlier
    assign wr_go   = (aw_fire || !bus.awready) && (w_fire || !bus.wready) && !bus.bvalid;
    assign wr_ofs  = aw_fire ? bus.awaddr[7:0] : awofs_q;
    assign wr_data = w_fire ? bus.wdata : wdata_q;
    assign wr_strb = w_fire ? bus.wstrb : wstrb_q;

    assign bus.rresp = resp_okay;

    // free-running timer and registered interrupt
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtime <= '0;
            mtip  <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            mtip  <= mtime >= mtimecmp;
        end
    end

    // compare register, per byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtimecmp <= '1;
        end else if (wr_go) begin
            for (int i = 0; i < strb_width; i++) begin
                if (wr_strb[i] && wr_ofs == mtimecmp_lo_ofs) begin
                    mtimecmp[8*i +: 8] <= wr_data[8*i +: 8];
                end
                if (wr_strb[i] && wr_ofs == mtimecmp_hi_ofs) begin
                    mtimecmp[32 + 8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // channel handshakes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.arready <= 1'b1;
            bus.rvalid  <= 1'b0;
            bus.awready <= 1'b1;
            bus.wready  <= 1'b1;
            bus.bvalid  <= 1'b0;
            bus.bresp   <= resp_okay;
        end else begin
            if (ar_fire) bus.arready <= 1'b0;
            else if (r_fire) bus.arready <= 1'b1;
            if (r_fire) bus.rvalid <= 1'b0;
            else if (ar_fire) bus.rvalid <= 1'b1;
            if (aw_fire) bus.awready <= 1'b0;
            else if (b_fire) bus.awready <= 1'b1;
            if (w_fire) bus.wready <= 1'b0;
            else if (b_fire) bus.wready <= 1'b1;
            if (b_fire) begin
                bus.bvalid <= 1'b0;
            end else if (wr_go) begin
                bus.bvalid <= 1'b1;
                // mtime is read-only
                if (wr_ofs == mtime_lo_ofs || wr_ofs == mtime_hi_ofs) bus.bresp <= resp_slverr;
                else bus.bresp <= resp_okay;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) awofs_q <= bus.awaddr[7:0];
        if (w_fire) begin
            wdata_q <= bus.wdata;
            wstrb_q <= bus.wstrb;
        end
        if (ar_fire) begin
            case (bus.araddr[7:0])
                mtime_lo_ofs:    bus.rdata <= mtime[31:0];
                mtime_hi_ofs:    bus.rdata <= mtime[63:32];
                mtimecmp_lo_ofs: bus.rdata <= mtimecmp[31:0];
                mtimecmp_hi_ofs: bus.rdata <= mtimecmp[63:32];
                default:         bus.rdata <= '0;
            endcase
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !bus.rvalid && !bus.bvalid && !mtip);

endmodule

// ==== logic/periph_top.sv ====
`timescale 1ns/1ps

module periph_top #(
    parameter int ram_depth = 64
) (
    input  logic                            clk,
    input  logic                            rst,

    input  logic [soc_pkg::addr_width-1:0]  s_araddr,
    input  logic                            s_arvalid,
    output logic                            s_arready,

    output logic [soc_pkg::data_width-1:0]  s_rdata,
    output soc_pkg::resp_t                  s_rresp,
    output logic                            s_rvalid,
    input  logic                            s_rready,

    input  logic [soc_pkg::addr_width-1:0]  s_awaddr,
    input  logic                            s_awvalid,
    output logic                            s_awready,

    input  logic [soc_pkg::data_width-1:0]  s_wdata,
    input  logic [soc_pkg::strb_width-1:0]  s_wstrb,
    input  logic                            s_wvalid,
    output logic                            s_wready,

    output soc_pkg::resp_t                  s_bresp,
    output logic                            s_bvalid,
    input  logic                            s_bready,

    output logic                            mtip
);

    axi_lite_if mgr_bus ();
    axi_lite_if clint_bus ();
    axi_lite_if ram_bus ();

    // external port onto the router's upstream bus
    assign mgr_bus.araddr  = s_araddr;
    assign mgr_bus.arvalid = s_arvalid;
    assign s_arready       = mgr_bus.arready;
    assign s_rdata         = mgr_bus.rdata;
    assign s_rresp         = mgr_bus.rresp;
    assign s_rvalid        = mgr_bus.rvalid;
    assign mgr_bus.rready  = s_rready;
    assign mgr_bus.awaddr  = s_awaddr;
    assign mgr_bus.awvalid = s_awvalid;
    assign s_awready       = mgr_bus.awready;
    assign mgr_bus.wdata   = s_wdata;
    assign mgr_bus.wstrb   = s_wstrb;
    assign mgr_bus.wvalid  = s_wvalid;
    assign s_wready        = mgr_bus.wready;
    assign s_bresp         = mgr_bus.bresp;
    assign s_bvalid        = mgr_bus.bvalid;
    assign mgr_bus.bready  = s_bready;

    axi_addr_router #(
        .ram_depth (ram_depth)
    ) i_axi_addr_router (
        .clk        (clk),
        .rst        (rst),
        .mgr        (mgr_bus),
        .clint_port (clint_bus),
        .ram_port   (ram_bus)
    );

    clint i_clint (
        .clk  (clk),
        .rst  (rst),
        .bus  (clint_bus),
        .mtip (mtip)
    );

    scratch_ram #(
        .ram_depth (ram_depth)
    ) i_scratch_ram (
        .clk (clk),
        .rst (rst),
        .bus (ram_bus)
    );

endmodule

// ==== logic/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram #(
    parameter int ram_depth = 64
) (
    input logic             clk,
    input logic             rst,
    axi_lite_if.subordinate bus
);
    import soc_pkg::*;

    localparam int idx_width = ram_depth > 1 ? $clog2(ram_depth) : 1;

    logic [data_width-1:0] mem [ram_depth];
    logic [idx_width-1:0]  awidx_q;
    logic [data_width-1:0] wdata_q;
    logic [strb_width-1:0] wstrb_q;
    logic                  ar_fire;
    logic                  r_fire;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  b_fire;
    logic                  wr_go;
    logic [idx_width-1:0]  wr_idx;
    logic [data_width-1:0] wr_data;
    logic [strb_width-1:0] wr_strb;

    // word index, wraps at ram_depth
    function automatic logic [idx_width-1:0] word_index(input logic [addr_width-1:0] addr);
        return idx_width'((addr >> $clog2(strb_width)) % ram_depth);
    endfunction

    assign ar_fire = bus.arvalid && bus.arready;
    assign r_fire  = bus.rvalid && bus.rready;
    assign aw_fire = bus.awvalid && bus.awready;
    assign w_fire  = bus.wvalid && bus.wready;
    assign b_fire  = bus.bvalid && bus.bready;

    assign wr_go   = (aw_fire || !bus.awready) && (w_fire || !bus.wready) && !bus.bvalid;
    assign wr_idx  = aw_fire ? word_index(bus.awaddr) : awidx_q;
    assign wr_data = w_fire ? bus.wdata : wdata_q;
    assign wr_strb = w_fire ? bus.wstrb : wstrb_q;

    assign bus.rresp = resp_okay;
    assign bus.bresp = resp_okay;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.arready <= 1'b1;
            bus.rvalid  <= 1'b0;
            bus.awready <= 1'b1;
            bus.wready  <= 1'b1;
            bus.bvalid  <= 1'b0;
        end else begin
            if (ar_fire) bus.arready <= 1'b0;
            else if (r_fire) bus.arready <= 1'b1;
            if (r_fire) bus.rvalid <= 1'b0;
            else if (ar_fire) bus.rvalid <= 1'b1;
            if (aw_fire) bus.awready <= 1'b0;
            else if (b_fire) bus.awready <= 1'b1;
            if (w_fire) bus.wready <= 1'b0;
            else if (b_fire) bus.wready <= 1'b1;
            if (b_fire) bus.bvalid <= 1'b0;
            else if (wr_go) bus.bvalid <= 1'b1;
        end
    end

    // storage and payload
    always_ff @(posedge clk) begin
        if (aw_fire) awidx_q <= word_index(bus.awaddr);
        if (w_fire) begin
            wdata_q <= bus.wdata;
            wstrb_q <= bus.wstrb;
        end
        if (wr_go) begin
            for (int i = 0; i < strb_width; i++) begin
                if (wr_strb[i]) mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
        if (ar_fire) bus.rdata <= mem[word_index(bus.araddr)];
    end

    // a pending response means both write halves were taken
    a_bvalid_after_write: assert property (@(posedge clk) disable iff (rst)
        bus.bvalid |-> !bus.awready && !bus.wready);

endmodule

// ==== logic/soc_pkg.sv ====
package soc_pkg;

    // bus widths
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // axi response codes
    typedef enum logic [1:0] {
        resp_okay   = 2'd0,
        resp_slverr = 2'd2,
        resp_decerr = 2'd3
    } resp_t;

    // address map
    localparam logic [addr_width-1:0] clint_base = 32'ha000_0000;
    localparam logic [addr_width-1:0] clint_span = 32'h0000_0100;
    localparam logic [addr_width-1:0] ram_base   = 32'h8000_0000;

    // clint register offsets within its 256-byte window
    localparam logic [7:0] mtime_lo_ofs    = 8'h48;
    localparam logic [7:0] mtime_hi_ofs    = 8'h4c;
    localparam logic [7:0] mtimecmp_lo_ofs = 8'h50;
    localparam logic [7:0] mtimecmp_hi_ofs = 8'h54;

endpackage

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;

    always #(period_ns / 2) clk = ~clk;

    // release reset just after a rising edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

// ==== test/tb_periph_top.sv ====
`timescale 1ns/1ps

module tb_periph_top;
    import soc_pkg::*;

    localparam int ram_depth = 64;
    localparam int max_cycles = 6000;

    logic                  clk;
    logic                  rst;
    logic [addr_width-1:0] s_araddr;
    logic                  s_arvalid;
    logic                  s_arready;
    logic [data_width-1:0] s_rdata;
    resp_t                 s_rresp;
    logic                  s_rvalid;
    logic                  s_rready;
    logic [addr_width-1:0] s_awaddr;
    logic                  s_awvalid;
    logic                  s_awready;
    logic [data_width-1:0] s_wdata;
    logic [strb_width-1:0] s_wstrb;
    logic                  s_wvalid;
    logic                  s_wready;
    resp_t                 s_bresp;
    logic                  s_bvalid;
    logic                  s_bready;
    logic                  mtip;
    logic [31:0]           shadow [ram_depth];
    int                    cycles = 0;

    tb_clk_gen #(.period_ns(20), .reset_cycles(2)) i_tb_clk_gen (.clk(clk), .rst(rst));

    periph_top #(.ram_depth(ram_depth)) i_periph_top (.*);

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("error: time %0t signal %s expected 0x%0h got 0x%0h",
                 $time, name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic protocol_failure(input string what);
        $display("error: time %0t %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "%s", what);
    endtask

    // 0 unmapped, 1 clint, 2 ram
    function automatic int region(input logic [31:0] addr);
        if (addr >= clint_base && addr - clint_base < clint_span) return 1;
        if (addr >= ram_base && addr - ram_base < 32'(ram_depth * 4)) return 2;
        return 0;
    endfunction

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                  input logic [31:0] new_word,
                                                  input logic [3:0] strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
        end
        return res;
    endfunction

    task automatic axi_read(input logic [31:0] addr, input bit stall,
                            output logic [31:0] data, output resp_t resp);
        int hold;
        int lat;
        hold = stall ? int'($urandom_range(5, 0)) : 0;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        s_rready  = !stall;
        // ready seen at negedge means transfer at the next rising edge
        do @(negedge clk); while (!s_arready);
        @(posedge clk);
        #2;
        s_arvalid = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!s_rvalid);
        assert (lat == (region(addr) != 0 ? 3 : 1))
            else report_mismatch("s_rvalid latency", 64'(region(addr) != 0 ? 3 : 1), 64'(lat));
        data = s_rdata;
        resp = s_rresp;
        if (stall) begin
            repeat (hold + 1) @(posedge clk);
            #2;
            s_rready = 1'b1;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input bit stall, output resp_t resp);
        int hold;
        int skew;
        int aw_delay;
        int w_delay;
        int cyc;
        int lat;
        bit aw_done;
        bit w_done;
        bit aw_fire;
        bit w_fire;
        hold = stall ? int'($urandom_range(5, 0)) : 0;
        skew = int'($urandom_range(2, 0));
        aw_delay = $urandom_range(1, 0) != 0 ? skew : 0;
        w_delay  = aw_delay == 0 ? skew : 0;
        s_awaddr  = addr;
        s_wdata   = data;
        s_wstrb   = strb;
        s_bready  = !stall;
        s_awvalid = aw_delay == 0;
        s_wvalid  = w_delay == 0;
        aw_done = 1'b0;
        w_done  = 1'b0;
        cyc = 0;
        // aw and w may land in either order
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            aw_fire = s_awvalid && s_awready;
            w_fire  = s_wvalid && s_wready;
            @(posedge clk);
            #2;
            cyc++;
            if (aw_fire) aw_done = 1'b1;
            if (w_fire) w_done = 1'b1;
            s_awvalid = !aw_done && cyc >= aw_delay;
            s_wvalid  = !w_done && cyc >= w_delay;
        end
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!s_bvalid);
        assert (lat == (region(addr) != 0 ? 3 : 1))
            else report_mismatch("s_bvalid latency", 64'(region(addr) != 0 ? 3 : 1), 64'(lat));
        resp = s_bresp;
        if (stall) begin
            repeat (hold + 1) @(posedge clk);
            #2;
            s_bready = 1'b1;
        end
        @(posedge clk);
        #2;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("TEST FAILED");
            $fatal(1, "timeout after %0d cycles", max_cycles);
        end
    end

    a_reset_state: assert property (@(posedge clk) $fell(rst) |->
        s_arready && s_awready && s_wready && !s_rvalid && !s_bvalid && !mtip)
        else protocol_failure("outputs not in reset state after reset");

    a_r_hold: assert property (@(posedge clk) disable iff (rst) s_rvalid && !s_rready |=>
        s_rvalid && $stable(s_rdata) && $stable(s_rresp) && !s_arready)
        else protocol_failure("read response not held while rready was low");

    a_b_hold: assert property (@(posedge clk) disable iff (rst) s_bvalid && !s_bready |=>
        s_bvalid && $stable(s_bresp) && !s_awready && !s_wready)
        else protocol_failure("write response not held while bready was low");

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] hi;
        logic [31:0] hi2;
        logic [31:0] lo;
        logic [63:0] prev_time;
        logic [3:0]  strb;
        resp_t       resp;
        int          idx;
        int          i;
        int          agree;
        void'($urandom(3256));
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b1;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b1;
        @(negedge rst);
        @(posedge clk);
        #2;

        // fill every ram word, pattern from the full address
        for (i = 0; i < ram_depth; i++) begin
            addr = ram_base + 32'(i * 4);
            shadow[i] = addr ^ 32'h5a5a_c3c3;
            axi_write(addr, shadow[i], 4'hf, $urandom_range(1, 0) != 0, resp);
            assert (resp == resp_okay) else report_mismatch("s_bresp", 64'(resp_okay), 64'(resp));
        end

        for (i = 0; i < 30; i++) begin
            idx  = int'($urandom_range(ram_depth - 1, 0));
            data = $urandom;
            strb = 4'($urandom_range(15, 0));
            shadow[idx] = apply_strobes(shadow[idx], data, strb);
            axi_write(ram_base + 32'(idx * 4), data, strb, $urandom_range(1, 0) != 0, resp);
            assert (resp == resp_okay) else report_mismatch("s_bresp", 64'(resp_okay), 64'(resp));
        end

        // decode errors leave ram untouched
        axi_write(32'h0000_1000, 32'hdead_beef, 4'hf, 1'b0, resp);
        assert (resp == resp_decerr) else report_mismatch("s_bresp", 64'(resp_decerr), 64'(resp));
        axi_write(ram_base + 32'(ram_depth * 4), 32'h1234_5678, 4'hf, 1'b1, resp);
        assert (resp == resp_decerr) else report_mismatch("s_bresp", 64'(resp_decerr), 64'(resp));
        axi_read(clint_base + clint_span, $urandom_range(1, 0) != 0, data, resp);
        assert (resp == resp_decerr) else report_mismatch("s_rresp", 64'(resp_decerr), 64'(resp));
        assert (data == 32'h0) else report_mismatch("s_rdata", 64'h0, 64'(data));
        axi_read(32'hffff_fffc, 1'b0, data, resp);
        assert (resp == resp_decerr) else report_mismatch("s_rresp", 64'(resp_decerr), 64'(resp));
        assert (data == 32'h0) else report_mismatch("s_rdata", 64'h0, 64'(data));
        // both rejected writes would wrap onto word 0
        axi_read(ram_base, 1'b0, data, resp);
        assert (resp == resp_okay) else report_mismatch("s_rresp", 64'(resp_okay), 64'(resp));
        assert (data == shadow[0]) else report_mismatch("s_rdata", 64'(shadow[0]), 64'(data));

        for (i = 0; i < 30; i++) begin
            idx = int'($urandom_range(ram_depth - 1, 0));
            axi_read(ram_base + 32'(idx * 4), $urandom_range(1, 0) != 0, data, resp);
            assert (resp == resp_okay) else report_mismatch("s_rresp", 64'(resp_okay), 64'(resp));
            assert (data == shadow[idx])
                else report_mismatch("s_rdata", 64'(shadow[idx]), 64'(data));
        end

        // mtime: hi, lo, hi again
        prev_time = '0;
        agree = 0;
        for (i = 0; i < 4; i++) begin
            axi_read(clint_base + 32'(mtime_hi_ofs), 1'b0, hi, resp);
            axi_read(clint_base + 32'(mtime_lo_ofs), 1'b0, lo, resp);
            axi_read(clint_base + 32'(mtime_hi_ofs), 1'b0, hi2, resp);
            assert (resp == resp_okay) else report_mismatch("s_rresp", 64'(resp_okay), 64'(resp));
            if (hi == hi2) begin
                assert ({hi, lo} > prev_time)
                    else report_mismatch("mtime", prev_time + 64'd1, {hi, lo});
                prev_time = {hi, lo};
                agree++;
            end
        end
        assert (agree > 0) else protocol_failure("mtime high word never read the same twice");
        axi_write(clint_base + 32'(mtime_lo_ofs), 32'h0, 4'hf, 1'b1, resp);
        assert (resp == resp_slverr) else report_mismatch("s_bresp", 64'(resp_slverr), 64'(resp));
        axi_write(clint_base + 32'(mtime_hi_ofs), 32'h0, 4'hf, 1'b0, resp);
        assert (resp == resp_slverr) else report_mismatch("s_bresp", 64'(resp_slverr), 64'(resp));

        // mtimecmp strobes, only bytes 0 and 2 change
        axi_write(clint_base + 32'(mtimecmp_lo_ofs), 32'h1122_3344, 4'b0101, 1'b1, resp);
        assert (resp == resp_okay) else report_mismatch("s_bresp", 64'(resp_okay), 64'(resp));
        axi_read(clint_base + 32'(mtimecmp_lo_ofs), 1'b1, data, resp);
        assert (data == 32'hff22_ff44) else report_mismatch("s_rdata", 64'hff22_ff44, 64'(data));
        axi_write(clint_base + 32'(mtimecmp_hi_ofs), 32'h0, 4'hf, 1'b0, resp);
        assert (resp == resp_okay) else report_mismatch("s_bresp", 64'(resp_okay), 64'(resp));
        axi_read(clint_base + 32'(mtimecmp_hi_ofs), 1'b0, data, resp);
        assert (data == 32'h0) else report_mismatch("s_rdata", 64'h0, 64'(data));
        assert (!mtip) else report_mismatch("mtip", 64'h0, 64'(mtip));

        // interrupt 200 ticks ahead
        axi_read(clint_base + 32'(mtime_lo_ofs), 1'b0, lo, resp);
        axi_write(clint_base + 32'(mtimecmp_lo_ofs), lo + 32'd200, 4'hf, 1'b0, resp);
        assert (resp == resp_okay) else report_mismatch("s_bresp", 64'(resp_okay), 64'(resp));
        assert (!mtip) else report_mismatch("mtip", 64'h0, 64'(mtip));
        for (i = 0; i < 300 && !mtip; i++) @(negedge clk);
        assert (mtip) else protocol_failure("mtip did not rise within 300 cycles");
        @(posedge clk);
        #2;
        axi_write(clint_base + 32'(mtimecmp_lo_ofs), 32'hffff_ffff, 4'hf, 1'b0, resp);
        assert (resp == resp_okay) else report_mismatch("s_bresp", 64'(resp_okay), 64'(resp));
        repeat (2) @(posedge clk);
        #2;
        assert (!mtip) else report_mismatch("mtip", 64'h0, 64'(mtip));
        axi_write(clint_base + 32'(mtimecmp_hi_ofs), 32'hffff_ffff, 4'hf, 1'b0, resp);
        assert (resp == resp_okay) else report_mismatch("s_bresp", 64'(resp_okay), 64'(resp));
        repeat (2) @(posedge clk);
        #2;
        assert (!mtip) else report_mismatch("mtip", 64'h0, 64'(mtip));

        $display("TEST PASSED");
        $finish;
    end

endmodule
